// ==== design/m72_pkg.sv ====
// AXI4-Lite offsets are word-aligned byte addresses on a 4-bit bus; only strobe bit 0 loads a register
package m72_pkg;

    // ========================================
    // AXI4-Lite bus
    // ========================================
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Register byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_SWITCHES = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_FLAGS    = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_DIP      = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_MIX_CTRL = 4'hC;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

    // ========================================
    // Board inputs and control
    // ========================================
    typedef struct packed {
        logic [3:0] p1_joystick;
        logic [3:0] p2_joystick;
        logic [3:0] p1_buttons;
        logic [3:0] p2_buttons;
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
    } player_in_t;

    // Bit 0 is coin counter 0
    typedef struct packed {
        logic [1:0] spare;
        logic       bank;
        logic       snd_brq_n;     // Sound bus request, active low
        logic       cblk;          // Colour blank
        logic       soft_flip_n;   // Screen flip, active low
        logic       coin1;
        logic       coin0;
    } sys_flags_t;

    // Bus writes the raw byte, the board reads the fields
    typedef union packed {
        logic [7:0] raw;
        sys_flags_t fields;
    } sys_flags_u;

    typedef struct packed {
        logic sprite_en;
        logic sprite_pal_en;
    } mix_ctrl_t;

    // ========================================
    // Pixels
    // ========================================
    typedef struct packed {
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } rgb5_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    typedef struct packed {
        rgb5_t      char_col;
        logic       char_pri;    // Character layer lets sprites through
        logic [7:0] obj_pix;
        rgb5_t      obj_pal;
    } layer_pix_t;

endpackage

// ==== design/m72_sys_regs.sv ====
// AXI4-Lite slave with one outstanding transaction per channel; unmapped reads give 0xFFFF, all responses OKAY
`timescale 1ns/10ps

module m72_sys_regs (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  m72_pkg::axil_req_t  axil_req,
    output m72_pkg::axil_rsp_t  axil_rsp,
    input  m72_pkg::player_in_t player_in,
    input  logic [15:0]         dip_sw,
    input  logic                tnsl,
    output m72_pkg::sys_flags_u sys_flags,
    output m72_pkg::mix_ctrl_t  mix_ctrl,
    output logic                nl
);
    import m72_pkg::*;

    logic                   wr_accept;
    logic                   rd_accept;
    logic                   bvalid_q;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [AXIL_ADDR_W-1:0] wr_off;
    logic [AXIL_ADDR_W-1:0] rd_off;
    logic [15:0]            switches;
    logic [15:0]            flags;
    logic [15:0]            rd_word;

    // ========================================
    // Port words
    // ========================================
    assign switches = {player_in.p2_buttons, player_in.p2_joystick,
                       player_in.p1_buttons, player_in.p1_joystick};

    // Test and R inputs are tied high on this board
    assign flags = {8'hff, tnsl, 3'b111, player_in.coin, player_in.start};

    // Full byte offsets, so an unaligned address hits no register
    assign wr_off = axil_req.awaddr;
    assign rd_off = axil_req.araddr;

    always_comb begin
        case (rd_off)
            REG_SWITCHES: rd_word = switches;
            REG_FLAGS:    rd_word = flags;
            REG_DIP:      rd_word = dip_sw;
            REG_MIX_CTRL: rd_word = {14'h0000, mix_ctrl};
            default:      rd_word = 16'hffff;
        endcase
    end

    // ========================================
    // Handshake
    // ========================================
    // Address and data must arrive together, and the last response must be gone
    assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
    assign rd_accept = axil_req.arvalid & ~rvalid_q;

    assign axil_rsp.awready = wr_accept;
    assign axil_rsp.wready  = wr_accept;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = AXI_RESP_OKAY;
    assign axil_rsp.arready = ~rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = AXI_RESP_OKAY;
    assign axil_rsp.rvalid  = rvalid_q;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Held while rvalid waits for rready
    always_ff @(posedge CLK_32M) begin
        if (rd_accept) begin
            rdata_q <= AXIL_DATA_W'(rd_word);
        end
    end

    // ========================================
    // Writable registers
    // ========================================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags.raw <= 8'h00;
            mix_ctrl      <= '{sprite_en: 1'b1, sprite_pal_en: 1'b1};
        end else if (wr_accept && axil_req.wstrb[0]) begin
            case (wr_off)
                REG_FLAGS: begin
                    sys_flags.raw <= axil_req.wdata[7:0];
                end
                REG_MIX_CTRL: begin
                    mix_ctrl <= mix_ctrl_t'(axil_req.wdata[1:0]);
                end
                default: begin
                    // Read-only or unmapped
                end
            endcase
        end
    end

    // Soft flip combined with the cabinet flip DIP
    assign nl = ~sys_flags.fields.soft_flip_n ^ dip_sw[8];

endmodule

// ==== design/m72_video_mix.sv ====
// Registered on every clock with no pixel enable; output lags the layer inputs by one cycle
`timescale 1ns/10ps

module m72_video_mix (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  m72_pkg::layer_pix_t layer,
    input  logic                cblk,
    input  m72_pkg::mix_ctrl_t  mix_ctrl,
    output m72_pkg::rgb8_t      rgb
);
    import m72_pkg::*;

    logic [4:0] idx_col;
    rgb5_t      obj_col;
    rgb5_t      pix_col;
    logic       obj_opaque;
    logic       obj_wins;
    rgb8_t      rgb_d;

    // 5 to 8 bits by repeating the top bits
    function automatic logic [7:0] expand5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // ========================================
    // Sprite colour
    // ========================================
    // Palette bypass shows the raw index as grey
    assign idx_col = {layer.obj_pix[3:0], 1'b0};

    assign obj_col = mix_ctrl.sprite_pal_en ? layer.obj_pal
                                            : rgb5_t'{idx_col, idx_col, idx_col};

    assign obj_opaque = |layer.obj_pix[3:0];   // Pen 0 is transparent

    // ========================================
    // Priority and blanking
    // ========================================
    assign obj_wins = obj_opaque & mix_ctrl.sprite_en & layer.char_pri;
    assign pix_col  = obj_wins ? obj_col : layer.char_col;

    always_comb begin
        if (cblk) begin
            rgb_d = '0;
        end else begin
            rgb_d.r = expand5(pix_col.r);
            rgb_d.g = expand5(pix_col.g);
            rgb_d.b = expand5(pix_col.b);
        end
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_d;
        end
    end

endmodule

// ==== design/m72_audio_mix.sv ====
// SAMPLE_W must be 2 to 16; the unsigned sample is left-aligned, no filtering, output lags by one cycle
`timescale 1ns/10ps

module m72_audio_mix #(
    parameter int SAMPLE_W = 8
) (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  logic signed [15:0]  music,
    input  logic [SAMPLE_W-1:0] sample,
    output logic [15:0]         audio_l,
    output logic [15:0]         audio_r
);

    localparam logic [SAMPLE_W-1:0] SIGN_BIT = 1'b1 << (SAMPLE_W - 1);

    logic [SAMPLE_W-1:0] sample_s;
    logic [15:0]         sample_al;
    logic signed [16:0]  sum;
    logic [15:0]         audio_q;

    // Offset binary to two's complement
    assign sample_s = sample ^ SIGN_BIT;

    assign sample_al = 16'(sample_s) << (16 - SAMPLE_W);

    // Sign extend both terms so the sum cannot wrap
    assign sum = {music[15], music} + {sample_al[15], sample_al};

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            audio_q <= 16'h0000;
        end else begin
            audio_q <= sum[16:1];   // Halve back to 16 bits
        end
    end

    // Mono mix on both channels
    assign audio_l = audio_q;
    assign audio_r = audio_q;

endmodule

// ==== design/m72_glue.sv ====
// Board glue only; layer pixels, TNSL and FM music come in from outside, one cycle latency on all paths
`timescale 1ns/10ps

module m72_glue #(
    parameter int SAMPLE_W = 8
) (
    input  logic                CLK_32M,
    input  logic                reset_n,

    // Host register bus
    input  m72_pkg::axil_req_t  axil_req,
    output m72_pkg::axil_rsp_t  axil_rsp,

    // Cabinet
    input  m72_pkg::player_in_t player_in,
    input  logic [15:0]         dip_sw,
    output logic [1:0]          coin_counter,
    output logic                nl,

    // Video
    input  logic                tnsl,
    input  m72_pkg::layer_pix_t layer,
    output m72_pkg::rgb8_t      rgb,

    // Audio
    input  logic signed [15:0]  music,
    input  logic [SAMPLE_W-1:0] sample,
    output logic [15:0]         audio_l,
    output logic [15:0]         audio_r
);
    import m72_pkg::*;

    sys_flags_u sys_flags;
    mix_ctrl_t  mix_ctrl;

    // ========================================
    // Register block
    // ========================================
    m72_sys_regs m72_sys_regs_i (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .player_in (player_in),
        .dip_sw    (dip_sw),
        .tnsl      (tnsl),
        .sys_flags (sys_flags),
        .mix_ctrl  (mix_ctrl),
        .nl        (nl)
    );

    assign coin_counter = {sys_flags.fields.coin1, sys_flags.fields.coin0};

    // ========================================
    // Mixers
    // ========================================
    m72_video_mix m72_video_mix_i (
        .CLK_32M  (CLK_32M),
        .reset_n  (reset_n),
        .layer    (layer),
        .cblk     (sys_flags.fields.cblk),
        .mix_ctrl (mix_ctrl),
        .rgb      (rgb)
    );

    m72_audio_mix #(
        .SAMPLE_W (SAMPLE_W)
    ) m72_audio_mix_i (
        .CLK_32M (CLK_32M),
        .reset_n (reset_n),
        .music   (music),
        .sample  (sample),
        .audio_l (audio_l),
        .audio_r (audio_r)
    );

endmodule

// ==== verification/m72_glue_props.sv ====
// Bound into every m72_sys_regs instance; checks only the response channels
`timescale 1ns/10ps

module m72_glue_props (
    input logic               CLK_32M,
    input logic               reset_n,
    input m72_pkg::axil_req_t axil_req,
    input m72_pkg::axil_rsp_t axil_rsp
);
    int fail_count = 0;

    // ========================================
    // Response channels
    // ========================================
    bvalid_held: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin fail_count++; $error("bvalid dropped before bready"); end

    rvalid_held: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin fail_count++; $error("rvalid or rdata changed before rready"); end

    reset_idle: assert property (@(posedge CLK_32M)
        !reset_n |-> !axil_rsp.bvalid && !axil_rsp.rvalid)
        else begin fail_count++; $error("response valid high in reset"); end

endmodule

bind m72_sys_regs m72_glue_props props_i (.*);

// ==== verification/m72_glue_checker.sv ====
// Expects inputs to change only on the falling edge; one outstanding read and write at a time
`timescale 1ns/10ps

module m72_glue_checker (
    input logic                CLK_32M,
    input logic                reset_n,
    input m72_pkg::axil_req_t  axil_req,
    input m72_pkg::axil_rsp_t  axil_rsp,
    input m72_pkg::player_in_t player_in,
    input logic [15:0]         dip_sw,
    input logic                tnsl,
    input m72_pkg::layer_pix_t layer,
    input logic [15:0]         music,
    input logic [7:0]          sample,
    input m72_pkg::rgb8_t      rgb,
    input logic [1:0]          coin_counter,
    input logic                nl,
    input logic [15:0]         audio_l,
    input logic [15:0]         audio_r
);
    import m72_pkg::*;

    logic [7:0]  flags_m;     // Model of the system-flags byte
    logic [1:0]  mix_m;       // {sprite_en, sprite_pal_en}
    rgb8_t       exp_rgb;
    logic [15:0] exp_audio;
    logic [15:0] exp_rdata;
    logic        wr_acc_q;    // Write accepted on the previous edge
    logic        rd_acc_q;    // Read accepted on the previous edge
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          wr_count = 0;
    int          b_count = 0;
    int          rd_count = 0;
    int          r_count = 0;

    function automatic rgb8_t model_rgb(layer_pix_t l, logic blank, logic [1:0] mc);
        rgb5_t      c;
        logic [4:0] grey;
        rgb8_t      o;
        grey = {l.obj_pix[3:0], 1'b0};
        if (mc[1] && l.char_pri && l.obj_pix[3:0] != 4'h0) begin
            c = mc[0] ? l.obj_pal : rgb5_t'{grey, grey, grey};
        end else begin
            c = l.char_col;
        end
        o = '{{c.r, c.r[4:2]}, {c.g, c.g[4:2]}, {c.b, c.b[4:2]}};
        return blank ? rgb8_t'(0) : o;
    endfunction

    // Signed music plus the re-centred sample scaled by 256, then halved
    function automatic logic [15:0] model_audio(logic [15:0] m, logic [7:0] s);
        int total;
        total = int'($signed(m)) + (int'(s) - 128) * 256;
        return 16'(total >>> 1);
    endfunction

    function automatic logic [15:0] model_read(logic [3:0] addr);
        case (addr)
            4'h0:    return {player_in.p2_buttons, player_in.p2_joystick,
                             player_in.p1_buttons, player_in.p1_joystick};
            4'h4:    return {8'hff, tnsl, 3'b111, player_in.coin, player_in.start};
            4'h8:    return dip_sw;
            4'hC:    return {14'h0000, mix_m};
            default: return 16'hffff;
        endcase
    endfunction

    task report(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        test_errors++;
    endtask

    task finish_test(input string name);
        if (wr_count != b_count || rd_count != r_count) begin
            $display("Transaction count mismatch: %0d/%0d writes, %0d/%0d reads completed",
                     b_count, wr_count, r_count, rd_count);
            test_errors++;
        end
        tests_run++;
        total_errors += test_errors;
        $display("Test %-16s %s (%0d errors)", name, test_errors == 0 ? "ok" : "bad",
                 test_errors);
        test_errors = 0;
    endtask

    always @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            flags_m   <= 8'h00;
            mix_m     <= 2'b11;
            exp_rgb   <= '0;
            exp_audio <= 16'h0000;
            wr_acc_q  <= 1'b0;
            rd_acc_q  <= 1'b0;
        end else begin
            if (rgb !== exp_rgb)
                report($sformatf("rgb %h, expected %h", rgb, exp_rgb));
            if (audio_l !== exp_audio || audio_r !== exp_audio)
                report($sformatf("audio %h/%h, expected %h", audio_l, audio_r, exp_audio));
            if (coin_counter !== flags_m[1:0])
                report($sformatf("coin_counter %b, expected %b", coin_counter, flags_m[1:0]));
            if (nl !== (~flags_m[2] ^ dip_sw[8]))
                report($sformatf("nl %b, expected %b", nl, ~flags_m[2] ^ dip_sw[8]));

            // Both write readies rise together
            if (axil_rsp.wready !== axil_rsp.awready)
                report($sformatf("wready %b, expected %b", axil_rsp.wready, axil_rsp.awready));
            if (wr_acc_q && axil_rsp.bvalid !== 1'b1)
                report("bvalid low one cycle after a write was accepted");
            if (rd_acc_q && axil_rsp.rvalid !== 1'b1)
                report("rvalid low one cycle after a read was accepted");

            if (axil_req.awvalid && axil_req.wvalid && axil_rsp.awready) begin
                wr_count++;
                if (axil_req.wstrb[0] && axil_req.awaddr == 4'h4)
                    flags_m <= axil_req.wdata[7:0];
                if (axil_req.wstrb[0] && axil_req.awaddr == 4'hC)
                    mix_m <= axil_req.wdata[1:0];
            end
            if (axil_rsp.bvalid && axil_req.bready) begin
                b_count++;
                if (axil_rsp.bresp !== 2'b00)
                    report($sformatf("bresp %b, expected OKAY", axil_rsp.bresp));
            end
            if (axil_req.arvalid && axil_rsp.arready) begin
                rd_count++;
                exp_rdata <= model_read(axil_req.araddr);
            end
            if (axil_rsp.rvalid && axil_req.rready) begin
                r_count++;
                if (axil_rsp.rdata !== {16'h0000, exp_rdata} || axil_rsp.rresp !== 2'b00)
                    report($sformatf("rdata %h resp %b, expected %h OKAY",
                                     axil_rsp.rdata, axil_rsp.rresp, exp_rdata));
            end

            wr_acc_q  <= axil_req.awvalid && axil_req.wvalid && axil_rsp.awready;
            rd_acc_q  <= axil_req.arvalid && axil_rsp.arready;
            exp_rgb   <= model_rgb(layer, flags_m[3], mix_m);
            exp_audio <= model_audio(music, sample);
        end
    end

endmodule

// ==== verification/m72_glue_tb.sv ====
// Assumes SAMPLE_W of 8; stimulus is repeatable from the fixed xorshift seed, not exhaustive
`timescale 1ns/10ps

module m72_glue_tb;
    import m72_pkg::*;

    localparam int WAIT_LIMIT = 100;   // Cycles before a handshake wait gives up

    logic         CLK_32M;
    logic         reset_n;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    player_in_t   player_in;
    logic [15:0]  dip_sw;
    logic         tnsl;
    layer_pix_t   layer;
    logic [15:0]  music;
    logic [7:0]   sample;
    rgb8_t        rgb;
    logic [1:0]   coin_counter;
    logic         nl;
    logic [15:0]  audio_l;
    logic [15:0]  audio_r;

    logic [31:0]  rng_state;
    int           timeouts;

    always #4 CLK_32M = ~CLK_32M;

    m72_glue #(.SAMPLE_W(8)) m72_glue_i (.*);

    m72_glue_checker chk (.*);

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Free-running pixel and audio stimulus
    always @(negedge CLK_32M) begin
        logic [63:0] pix;
        if (reset_n) begin
            pix    = {next_rand(), next_rand()};
            layer  = pix[38:0];
            music  = 16'(next_rand() >> 16);
            sample = 8'(next_rand() >> 24);
        end
    end

    // Waits until cond is seen at a rising edge, or gives up
    task wait_write_accept();
        int n;
        n = 0;
        @(posedge CLK_32M);
        while (!axil_rsp.awready && n < WAIT_LIMIT) begin
            @(posedge CLK_32M);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout: write was never accepted, at %0t", $time);
            timeouts++;
        end
    endtask

    task axil_write(input logic [3:0] addr, input logic [31:0] data,
                    input logic [3:0] strb, input int delay);
        int n;
        @(negedge CLK_32M);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        wait_write_accept();
        @(negedge CLK_32M);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        repeat (delay) @(negedge CLK_32M);
        axil_req.bready = 1'b1;
        n = 0;
        @(posedge CLK_32M);
        while (!axil_rsp.bvalid && n < WAIT_LIMIT) begin
            @(posedge CLK_32M);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout: no write response arrived, at %0t", $time);
            timeouts++;
        end
        @(negedge CLK_32M);
        axil_req.bready = 1'b0;
    endtask

    task axil_read(input logic [3:0] addr, input int delay);
        int n;
        @(negedge CLK_32M);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        @(posedge CLK_32M);
        while (!axil_rsp.arready && n < WAIT_LIMIT) begin
            @(posedge CLK_32M);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout: read was never accepted, at %0t", $time);
            timeouts++;
        end
        @(negedge CLK_32M);
        axil_req.arvalid = 1'b0;
        repeat (delay) @(negedge CLK_32M);
        axil_req.rready = 1'b1;
        n = 0;
        @(posedge CLK_32M);
        while (!axil_rsp.rvalid && n < WAIT_LIMIT) begin
            @(posedge CLK_32M);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout: no read data arrived, at %0t", $time);
            timeouts++;
        end
        @(negedge CLK_32M);
        axil_req.rready = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        CLK_32M   = 1'b0;
        reset_n   = 1'b0;
        axil_req  = '0;
        player_in = '0;
        dip_sw    = 16'h0000;
        tnsl      = 1'b0;
        layer     = '0;
        music     = 16'h0000;
        sample    = 8'h80;
        rng_state = 32'd31590;
        timeouts  = 0;

        // ========================================
        // Reset and read-only ports
        // ========================================
        dip_sw = 16'(next_rand());
        repeat (10) @(negedge CLK_32M);
        reset_n = 1'b1;
        axil_read(REG_MIX_CTRL, 0);
        repeat (3) @(negedge CLK_32M);
        chk.finish_test("reset state");

        repeat (8) begin
            @(negedge CLK_32M);
            player_in = 21'(next_rand());
            dip_sw    = 16'(next_rand());
            tnsl      = 1'(next_rand() >> 31);
            axil_read(REG_SWITCHES, 0);
            axil_read(REG_FLAGS, 0);
            axil_read(REG_DIP, 0);
            axil_read(4'h6, 0);            // Unmapped offset
        end
        chk.finish_test("read-only ports");

        // ========================================
        // Writable registers and mixers
        // ========================================
        repeat (12) begin
            r = next_rand();
            axil_write(REG_FLAGS, next_rand(), r[3:0], 0);
            axil_read(REG_FLAGS, 0);
        end
        chk.finish_test("system flags");

        repeat (12) begin
            axil_write(REG_MIX_CTRL, next_rand(), 4'hf, 0);
            axil_write(REG_FLAGS, next_rand() & 32'h08, 4'h1, 0);
            repeat (20) @(negedge CLK_32M);
        end
        chk.finish_test("video priority");

        repeat (200) @(negedge CLK_32M);
        chk.finish_test("audio sum");

        repeat (16) begin
            r = next_rand();
            if (r[0]) begin
                axil_write({r[3:2], 2'b00}, next_rand(), 4'h1, r[10:8] % 5);
            end else begin
                axil_read({r[3:2], 2'b00}, r[10:8] % 5);
            end
        end
        chk.finish_test("back-pressure");

        $display("Tests: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 chk.tests_run, chk.total_errors, timeouts,
                 m72_glue_i.m72_sys_regs_i.props_i.fail_count);
        if (chk.total_errors == 0 && timeouts == 0 &&
            m72_glue_i.m72_sys_regs_i.props_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/m72_pkg.sv
design/m72_sys_regs.sv
design/m72_video_mix.sv
design/m72_audio_mix.sv
design/m72_glue.sv
verification/m72_glue_props.sv
verification/m72_glue_checker.sv
verification/m72_glue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= m72_glue_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
